/* verilog/dcache_pkg.sv */
// data cache package
// address, word and line widths, vector types, controller states

package dcache_pkg;

  localparam int ADDR_BITS   = 32;
  localparam int WORD_BITS   = 64;
  localparam int OFFSET_BITS = 4;   // 16-byte lines
  localparam int LINE_BEATS  = 2;   // words per line, beats per burst
  localparam int WAYS        = 2;

  typedef logic [ADDR_BITS-1:0]            addr_t;
  typedef logic [WORD_BITS-1:0]            word_t;
  typedef logic [WORD_BITS/8-1:0]          strb_t;
  typedef logic [LINE_BEATS*WORD_BITS-1:0] line_t;  // low word at offset 0
  typedef logic [$clog2(WAYS)-1:0]         way_t;

  // write-back runs before refill on a dirty victim
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HIT,
    ST_WB_ADDR,
    ST_WB_DATA,
    ST_WB_RESP,
    ST_RF_ADDR,
    ST_RF_DATA
  } cache_state_e;

endpackage

/* verilog/tag_if.sv */
// controller to tag store connection
// combinational lookup, victim report, one-cycle update

interface tag_if #(
  parameter int INDEX_BITS = 6
);
  import dcache_pkg::*;

  localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

  logic [INDEX_BITS-1:0] lookup_index;
  logic [TAG_BITS-1:0]   lookup_tag;
  logic                  hit;
  way_t                  hit_way;
  way_t                  victim_way;
  logic                  victim_dirty;
  logic [TAG_BITS-1:0]   victim_tag;   // stored tag of the victim way

  logic                  upd_en;
  way_t                  upd_way;
  logic [INDEX_BITS-1:0] upd_index;
  logic [TAG_BITS-1:0]   upd_tag;
  logic                  upd_valid;
  logic                  upd_dirty;

  modport ctrl (
    output lookup_index, lookup_tag,
    output upd_en, upd_way, upd_index, upd_tag, upd_valid, upd_dirty,
    input  hit, hit_way, victim_way, victim_dirty, victim_tag
  );

  modport store (
    input  lookup_index, lookup_tag,
    input  upd_en, upd_way, upd_index, upd_tag, upd_valid, upd_dirty,
    output hit, hit_way, victim_way, victim_dirty, victim_tag
  );

endinterface

/* verilog/line_if.sv */
// controller to line array connection

interface line_if #(
  parameter int INDEX_BITS = 6
);
  import dcache_pkg::*;

  logic [INDEX_BITS-1:0]       index;
  way_t                        way;
  logic                        wr_en;
  logic [$bits(line_t)/8-1:0]  byte_en;
  line_t                       wr_line;
  line_t                       rd_line;  // one cycle after index

  modport ctrl (
    output index, way, wr_en, byte_en, wr_line,
    input  rd_line
  );

  modport array (
    input  index, way, wr_en, byte_en, wr_line,
    output rd_line
  );

endinterface

/* verilog/dcache_tag_store.sv */
// tag, valid and dirty bits for each way and set
// hit detection and free-running victim select

module dcache_tag_store #(
  parameter int INDEX_BITS = 6
) (
  input logic  clk,
  input logic  rst,
  tag_if.store tag_p
);
  import dcache_pkg::*;

  localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int SETS     = 1 << INDEX_BITS;

  logic [TAG_BITS-1:0] tag_q   [WAYS][SETS];
  logic                valid_q [WAYS][SETS];
  logic                dirty_q [WAYS][SETS];
  way_t                victim_q;
  logic [WAYS-1:0]     way_hit;

  always_comb begin
    tag_p.hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = valid_q[w][tag_p.lookup_index] &&
                   (tag_q[w][tag_p.lookup_index] == tag_p.lookup_tag);
      if (way_hit[w]) begin
        tag_p.hit_way = way_t'(w);
      end
    end
  end

  assign tag_p.hit          = |way_hit;
  assign tag_p.victim_way   = victim_q;
  assign tag_p.victim_dirty = dirty_q[victim_q][tag_p.lookup_index];
  assign tag_p.victim_tag   = tag_q[victim_q][tag_p.lookup_index];

  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= '0;
      for (int w = 0; w < WAYS; w++) begin
        for (int s = 0; s < SETS; s++) begin
          tag_q[w][s]   <= '0;
          valid_q[w][s] <= 1'b0;
          dirty_q[w][s] <= 1'b0;
        end
      end
    end else begin
      victim_q <= victim_q + 1'b1;  // advances every cycle
      if (tag_p.upd_en) begin
        tag_q[tag_p.upd_way][tag_p.upd_index]   <= tag_p.upd_tag;
        valid_q[tag_p.upd_way][tag_p.upd_index] <= tag_p.upd_valid;
        dirty_q[tag_p.upd_way][tag_p.upd_index] <= tag_p.upd_dirty;
      end
    end
  end

endmodule

/* verilog/dcache_line_array.sv */
// line storage for both ways
// byte write enables, registered read of the addressed line

module dcache_line_array #(
  parameter int INDEX_BITS = 6
) (
  input logic   clk,
  line_if.array line_p
);
  import dcache_pkg::*;

  localparam int SETS       = 1 << INDEX_BITS;
  localparam int LINE_BYTES = $bits(line_t) / 8;

  line_t mem_q [WAYS][SETS];
  line_t merged;

  // stored line with the enabled bytes replaced
  always_comb begin
    merged = mem_q[line_p.way][line_p.index];
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (line_p.byte_en[b]) begin
        merged[b*8 +: 8] = line_p.wr_line[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line_p.wr_en) begin
      mem_q[line_p.way][line_p.index] <= merged;
    end
    // new data shows up on a write, so the last refill beat is visible in hit
    line_p.rd_line <= line_p.wr_en ? merged : mem_q[line_p.way][line_p.index];
  end

endmodule

/* verilog/dcache_ctrl.sv */
// cache controller FSM
// CPU handshakes, write-back and refill bursts, write merge

module dcache_ctrl #(
  parameter int INDEX_BITS = 6
) (
  input  logic              clk,
  input  logic              rst,
  tag_if.ctrl               tag_p,
  line_if.ctrl              line_p,
  input  logic              cpu_ar_valid_i,
  output logic              cpu_ar_ready_o,
  input  dcache_pkg::addr_t cpu_ar_addr_i,
  output logic              cpu_r_valid_o,
  input  logic              cpu_r_ready_i,
  output dcache_pkg::word_t cpu_r_data_o,
  input  logic              cpu_aw_valid_i,
  output logic              cpu_aw_ready_o,
  input  dcache_pkg::addr_t cpu_aw_addr_i,
  input  logic              cpu_w_valid_i,
  output logic              cpu_w_ready_o,
  input  dcache_pkg::word_t cpu_w_data_i,
  input  dcache_pkg::strb_t cpu_w_strb_i,
  output logic              cpu_b_valid_o,
  input  logic              cpu_b_ready_i,
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output dcache_pkg::addr_t mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  dcache_pkg::word_t mem_r_data_i,
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output dcache_pkg::addr_t mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output dcache_pkg::word_t mem_w_data_o,
  input  logic              mem_b_valid_i,
  output logic              mem_b_ready_o
);
  import dcache_pkg::*;

  localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int BEAT_BITS  = $clog2(LINE_BEATS);
  localparam int WORD_BYTES = WORD_BITS / 8;
  localparam int LINE_BYTES = $bits(line_t) / 8;

  cache_state_e         state_q, state_d;
  addr_t                req_addr_q;
  logic                 is_write_q;
  way_t                 way_q;
  logic                 w_done_q;
  logic                 accept_q;
  logic [BEAT_BITS-1:0] beat_q;
  logic                 ar_hs, aw_hs, req_hs, w_hs;
  addr_t                in_addr, cur_addr;
  logic [BEAT_BITS-1:0] word_sel;
  logic                 last_beat;

  assign cpu_ar_ready_o = accept_q;
  assign cpu_aw_ready_o = accept_q & ~cpu_ar_valid_i;  // read wins
  assign ar_hs  = cpu_ar_valid_i & cpu_ar_ready_o;
  assign aw_hs  = cpu_aw_valid_i & cpu_aw_ready_o;
  assign req_hs = ar_hs | aw_hs;

  assign in_addr   = ar_hs ? cpu_ar_addr_i : cpu_aw_addr_i;
  assign cur_addr  = (state_q == ST_IDLE) ? in_addr : req_addr_q;
  assign word_sel  = req_addr_q[OFFSET_BITS-1 -: BEAT_BITS];
  assign last_beat = (beat_q == BEAT_BITS'(LINE_BEATS - 1));

  assign tag_p.lookup_index = cur_addr[OFFSET_BITS +: INDEX_BITS];
  assign tag_p.lookup_tag   = cur_addr[ADDR_BITS-1 -: TAG_BITS];

  // line is read on the handshake cycle, ready in hit or write-back
  assign line_p.index = cur_addr[OFFSET_BITS +: INDEX_BITS];
  assign line_p.way   = (state_q != ST_IDLE) ? way_q :
                        tag_p.hit ? tag_p.hit_way : tag_p.victim_way;

  assign cpu_r_valid_o = (state_q == ST_HIT) & ~is_write_q;
  assign cpu_r_data_o  = line_p.rd_line[word_sel*WORD_BITS +: WORD_BITS];
  assign cpu_w_ready_o = (state_q == ST_HIT) & is_write_q & ~w_done_q;
  assign cpu_b_valid_o = (state_q == ST_HIT) & is_write_q & w_done_q;
  assign w_hs          = cpu_w_valid_i & cpu_w_ready_o;

  assign mem_ar_addr_o = {req_addr_q[ADDR_BITS-1:OFFSET_BITS], OFFSET_BITS'(0)};
  assign mem_w_data_o  = line_p.rd_line[beat_q*WORD_BITS +: WORD_BITS];

  always_comb begin
    state_d         = state_q;
    tag_p.upd_en    = 1'b0;
    tag_p.upd_way   = way_q;
    tag_p.upd_index = req_addr_q[OFFSET_BITS +: INDEX_BITS];
    tag_p.upd_tag   = req_addr_q[ADDR_BITS-1 -: TAG_BITS];
    tag_p.upd_valid = 1'b1;
    tag_p.upd_dirty = 1'b0;
    line_p.wr_en    = 1'b0;
    line_p.byte_en  = '0;
    line_p.wr_line  = {LINE_BEATS{mem_r_data_i}};
    case (state_q)
      ST_IDLE: begin
        if (req_hs && tag_p.hit) begin
          state_d = ST_HIT;
        end else if (req_hs) begin
          tag_p.upd_en    = 1'b1;  // victim out until refilled
          tag_p.upd_way   = tag_p.victim_way;
          tag_p.upd_index = tag_p.lookup_index;
          tag_p.upd_tag   = tag_p.victim_tag;
          tag_p.upd_valid = 1'b0;
          state_d = tag_p.victim_dirty ? ST_WB_ADDR : ST_RF_ADDR;
        end
      end
      ST_HIT: begin
        if (w_hs) begin
          tag_p.upd_en    = 1'b1;
          tag_p.upd_dirty = 1'b1;
          line_p.wr_en    = 1'b1;
          line_p.byte_en  = LINE_BYTES'(cpu_w_strb_i) << (word_sel * WORD_BYTES);
          line_p.wr_line  = {LINE_BEATS{cpu_w_data_i}};
        end
        if ((cpu_r_valid_o && cpu_r_ready_i) || (cpu_b_valid_o && cpu_b_ready_i)) begin
          state_d = ST_IDLE;
        end
      end
      ST_WB_ADDR: if (mem_aw_valid_o && mem_aw_ready_i) state_d = ST_WB_DATA;
      ST_WB_DATA: if (mem_w_valid_o && mem_w_ready_i && last_beat) state_d = ST_WB_RESP;
      ST_WB_RESP: if (mem_b_valid_i && mem_b_ready_o) state_d = ST_RF_ADDR;
      ST_RF_ADDR: if (mem_ar_valid_o && mem_ar_ready_i) state_d = ST_RF_DATA;
      ST_RF_DATA: begin
        if (mem_r_valid_i && mem_r_ready_o) begin
          line_p.wr_en   = 1'b1;
          line_p.byte_en = LINE_BYTES'({WORD_BYTES{1'b1}}) << (beat_q * WORD_BYTES);
          if (last_beat) begin
            tag_p.upd_en = 1'b1;  // new tag, valid and clean
            state_d = ST_HIT;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= ST_IDLE;
      accept_q       <= 1'b0;
      is_write_q     <= 1'b0;
      way_q          <= '0;
      w_done_q       <= 1'b0;
      beat_q         <= '0;
      mem_ar_valid_o <= 1'b0;
      mem_r_ready_o  <= 1'b0;
      mem_aw_valid_o <= 1'b0;
      mem_w_valid_o  <= 1'b0;
      mem_b_ready_o  <= 1'b0;
    end else begin
      state_q  <= state_d;
      accept_q <= (state_d == ST_IDLE);
      case (state_q)
        ST_IDLE: begin
          if (req_hs) begin
            is_write_q <= aw_hs;
            w_done_q   <= 1'b0;
            way_q      <= tag_p.hit ? tag_p.hit_way : tag_p.victim_way;
            if (!tag_p.hit && tag_p.victim_dirty) mem_aw_valid_o <= 1'b1;
            if (!tag_p.hit && !tag_p.victim_dirty) mem_ar_valid_o <= 1'b1;
          end
        end
        ST_HIT: if (w_hs) w_done_q <= 1'b1;
        ST_WB_ADDR: begin
          if (mem_aw_valid_o && mem_aw_ready_i) begin
            mem_aw_valid_o <= 1'b0;
            mem_w_valid_o  <= 1'b1;
          end
        end
        ST_WB_DATA: begin
          if (mem_w_valid_o && mem_w_ready_i) begin
            beat_q <= last_beat ? '0 : beat_q + 1'b1;
            if (last_beat) begin
              mem_w_valid_o <= 1'b0;
              mem_b_ready_o <= 1'b1;
            end
          end
        end
        ST_WB_RESP: begin
          if (mem_b_valid_i && mem_b_ready_o) begin
            mem_b_ready_o  <= 1'b0;
            mem_ar_valid_o <= 1'b1;
          end
        end
        ST_RF_ADDR: begin
          if (mem_ar_valid_o && mem_ar_ready_i) begin
            mem_ar_valid_o <= 1'b0;
            mem_r_ready_o  <= 1'b1;
          end
        end
        ST_RF_DATA: begin
          if (mem_r_valid_i && mem_r_ready_o) begin
            beat_q <= last_beat ? '0 : beat_q + 1'b1;
            if (last_beat) mem_r_ready_o <= 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  // request address and write-back target
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && req_hs) begin
      req_addr_q    <= in_addr;
      mem_aw_addr_o <= {tag_p.victim_tag, tag_p.lookup_index, OFFSET_BITS'(0)};
    end
  end

endmodule

/* verilog/dcache_top.sv */
// two-way write-back data cache top level
// CPU and memory channels, controller, tag store, line array

module dcache_top #(
  parameter int INDEX_BITS = 6
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cpu_ar_valid_i,
  output logic              cpu_ar_ready_o,
  input  dcache_pkg::addr_t cpu_ar_addr_i,
  output logic              cpu_r_valid_o,
  input  logic              cpu_r_ready_i,
  output dcache_pkg::word_t cpu_r_data_o,
  input  logic              cpu_aw_valid_i,
  output logic              cpu_aw_ready_o,
  input  dcache_pkg::addr_t cpu_aw_addr_i,
  input  logic              cpu_w_valid_i,
  output logic              cpu_w_ready_o,
  input  dcache_pkg::word_t cpu_w_data_i,
  input  dcache_pkg::strb_t cpu_w_strb_i,
  output logic              cpu_b_valid_o,
  input  logic              cpu_b_ready_i,
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output dcache_pkg::addr_t mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  dcache_pkg::word_t mem_r_data_i,
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output dcache_pkg::addr_t mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output dcache_pkg::word_t mem_w_data_o,
  input  logic              mem_b_valid_i,
  output logic              mem_b_ready_o
);

  tag_if  #(.INDEX_BITS(INDEX_BITS)) tag_bus ();
  line_if #(.INDEX_BITS(INDEX_BITS)) line_bus ();

  dcache_ctrl #(.INDEX_BITS(INDEX_BITS)) ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .tag_p          (tag_bus.ctrl),
    .line_p         (line_bus.ctrl),
    .cpu_ar_valid_i (cpu_ar_valid_i),
    .cpu_ar_ready_o (cpu_ar_ready_o),
    .cpu_ar_addr_i  (cpu_ar_addr_i),
    .cpu_r_valid_o  (cpu_r_valid_o),
    .cpu_r_ready_i  (cpu_r_ready_i),
    .cpu_r_data_o   (cpu_r_data_o),
    .cpu_aw_valid_i (cpu_aw_valid_i),
    .cpu_aw_ready_o (cpu_aw_ready_o),
    .cpu_aw_addr_i  (cpu_aw_addr_i),
    .cpu_w_valid_i  (cpu_w_valid_i),
    .cpu_w_ready_o  (cpu_w_ready_o),
    .cpu_w_data_i   (cpu_w_data_i),
    .cpu_w_strb_i   (cpu_w_strb_i),
    .cpu_b_valid_o  (cpu_b_valid_o),
    .cpu_b_ready_i  (cpu_b_ready_i),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .mem_aw_valid_o (mem_aw_valid_o),
    .mem_aw_ready_i (mem_aw_ready_i),
    .mem_aw_addr_o  (mem_aw_addr_o),
    .mem_w_valid_o  (mem_w_valid_o),
    .mem_w_ready_i  (mem_w_ready_i),
    .mem_w_data_o   (mem_w_data_o),
    .mem_b_valid_i  (mem_b_valid_i),
    .mem_b_ready_o  (mem_b_ready_o)
  );

  dcache_tag_store #(.INDEX_BITS(INDEX_BITS)) tag_store_i (
    .clk   (clk),
    .rst   (rst),
    .tag_p (tag_bus.store)
  );

  dcache_line_array #(.INDEX_BITS(INDEX_BITS)) line_array_i (
    .clk    (clk),
    .line_p (line_bus.array)
  );

endmodule

/* bench/dcache_assert.sv */
// memory-side protocol and CPU write assertions bound to the cache controller

module dcache_assert (
  input logic                     clk,
  input logic                     rst,
  input logic                     cpu_ar_valid_i,
  input logic                     cpu_ar_ready_o,
  input dcache_pkg::addr_t        cpu_ar_addr_i,
  input logic                     cpu_aw_valid_i,
  input logic                     cpu_aw_ready_o,
  input dcache_pkg::addr_t        cpu_aw_addr_i,
  input logic                     cpu_r_valid_o,
  input logic                     cpu_b_valid_o,
  input logic                     cpu_b_ready_i,
  input logic                     mem_ar_valid_o,
  input logic                     mem_ar_ready_i,
  input dcache_pkg::addr_t        mem_ar_addr_o,
  input logic                     mem_aw_valid_o,
  input logic                     mem_aw_ready_i,
  input dcache_pkg::addr_t        mem_aw_addr_o,
  input logic                     mem_w_valid_o,
  input logic                     mem_w_ready_i,
  input dcache_pkg::word_t        mem_w_data_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import dcache_pkg::*;

  addr_t req_addr_q;  // address of the request in flight
  logic  in_write_q;  // from write address to write response

  always @(posedge clk) begin
    if (rst) begin
      in_write_q <= 1'b0;
    end else if (cpu_ar_valid_i && cpu_ar_ready_o) begin
      req_addr_q <= cpu_ar_addr_i;
    end else if (cpu_aw_valid_i && cpu_aw_ready_o) begin
      req_addr_q <= cpu_aw_addr_i;
      in_write_q <= 1'b1;
    end else if (cpu_b_valid_o && cpu_b_ready_i) begin
      in_write_q <= 1'b0;
    end
  end

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o))
    else $error("mem_ar dropped or changed before accept");
  aw_hold: assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid_o && !mem_aw_ready_i |=> mem_aw_valid_o && $stable(mem_aw_addr_o))
    else $error("mem_aw dropped or changed before accept");
  w_hold: assert property (@(posedge clk) disable iff (rst)
    mem_w_valid_o && !mem_w_ready_i |=> mem_w_valid_o && $stable(mem_w_data_o))
    else $error("mem_w dropped or changed before accept");
  ar_line: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o |-> mem_ar_addr_o == {req_addr_q[ADDR_BITS-1:OFFSET_BITS], OFFSET_BITS'(0)})
    else $error("mem_ar address is not the aligned request line");
  aw_line: assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid_o |-> mem_aw_addr_o[OFFSET_BITS-1:0] == '0 &&
      mem_aw_addr_o[ADDR_BITS-1:OFFSET_BITS] != req_addr_q[ADDR_BITS-1:OFFSET_BITS])
    else $error("mem_aw address not line aligned or equal to the request line");
  no_r_in_write: assert property (@(posedge clk) disable iff (rst)
    in_write_q |-> !cpu_r_valid_o)
    else $error("read data valid during a write");

endmodule

bind dcache_ctrl dcache_assert assert_i (
  .clk(clk), .rst(rst),
  .cpu_ar_valid_i(cpu_ar_valid_i), .cpu_ar_ready_o(cpu_ar_ready_o),
  .cpu_ar_addr_i(cpu_ar_addr_i),
  .cpu_aw_valid_i(cpu_aw_valid_i), .cpu_aw_ready_o(cpu_aw_ready_o),
  .cpu_aw_addr_i(cpu_aw_addr_i),
  .cpu_r_valid_o(cpu_r_valid_o), .cpu_b_valid_o(cpu_b_valid_o), .cpu_b_ready_i(cpu_b_ready_i),
  .mem_ar_valid_o(mem_ar_valid_o), .mem_ar_ready_i(mem_ar_ready_i),
  .mem_ar_addr_o(mem_ar_addr_o),
  .mem_aw_valid_o(mem_aw_valid_o), .mem_aw_ready_i(mem_aw_ready_i),
  .mem_aw_addr_o(mem_aw_addr_o),
  .mem_w_valid_o(mem_w_valid_o), .mem_w_ready_i(mem_w_ready_i), .mem_w_data_o(mem_w_data_o)
);

/* bench/tb_dcache.sv */
// testbench for the two-way data cache
// clock, reset, golden-file driver, memory model with write-back checks

module tb_dcache;
  timeunit 1ns;
  timeprecision 1ps;
  import dcache_pkg::*;

  localparam int TIMEOUT = 200;

  logic  clk, rst;
  logic  cpu_ar_valid_i, cpu_ar_ready_o, cpu_r_valid_o, cpu_r_ready_i;
  logic  cpu_aw_valid_i, cpu_aw_ready_o, cpu_w_valid_i, cpu_w_ready_o;
  logic  cpu_b_valid_o, cpu_b_ready_i;
  addr_t cpu_ar_addr_i, cpu_aw_addr_i;
  word_t cpu_r_data_o, cpu_w_data_i;
  strb_t cpu_w_strb_i;
  logic  mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  logic  mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
  logic  mem_b_valid_i, mem_b_ready_o;
  addr_t mem_ar_addr_o, mem_aw_addr_o;
  word_t mem_r_data_i, mem_w_data_o;

  logic [63:0] golden [0:255];
  word_t wmem [addr_t];     // words written back by the cache
  word_t ref_mem [addr_t];  // expected memory contents after CPU writes
  addr_t rd_addr, wr_addr;
  int    rd_beat, wr_beat, bursts, errors, passed, failed;
  bit    run_ok;

  dcache_top #(.INDEX_BITS(6)) dcache_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // A in the upper half, ~A in the lower half
  function automatic word_t rule_word(addr_t a);
    return {a, ~a};
  endfunction

  function automatic word_t mem_word(addr_t a);
    return wmem.exists(a) ? wmem[a] : rule_word(a);
  endfunction

  function automatic word_t ref_word(addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : rule_word(a);
  endfunction

  // memory model answers one cycle after each valid
  always @(posedge clk) begin
    if (rst) begin
      mem_ar_ready_i <= 1'b0;
      mem_r_valid_i  <= 1'b0;
      mem_aw_ready_i <= 1'b0;
      mem_w_ready_i  <= 1'b0;
      mem_b_valid_i  <= 1'b0;
    end else begin
      mem_ar_ready_i <= mem_ar_valid_o && !mem_ar_ready_i;
      if (mem_ar_valid_o && mem_ar_ready_i) begin
        rd_addr       <= mem_ar_addr_o;
        rd_beat       <= 0;
        mem_r_valid_i <= 1'b1;
        mem_r_data_i  <= mem_word(mem_ar_addr_o);
      end else if (mem_r_valid_i && mem_r_ready_o) begin
        if (rd_beat == 0) begin
          rd_beat      <= 1;
          mem_r_data_i <= mem_word(rd_addr + 8);  // high word
        end else begin
          mem_r_valid_i <= 1'b0;
        end
      end
      mem_aw_ready_i <= mem_aw_valid_o && !mem_aw_ready_i;
      if (mem_aw_valid_o && mem_aw_ready_i) begin
        wr_addr <= mem_aw_addr_o;
        wr_beat <= 0;
      end
      mem_w_ready_i <= mem_w_valid_o && !mem_w_ready_i;
      if (mem_w_valid_o && mem_w_ready_i) begin
        assert (mem_w_data_o == ref_word(wr_addr + 8 * wr_beat)) else begin
          $display("MISMATCH at %0t: write-back to %h got %h expected %h", $time,
                   wr_addr + 8 * wr_beat, mem_w_data_o, ref_word(wr_addr + 8 * wr_beat));
          errors++;
        end
        assert (wr_addr[3:0] == 4'h0 && wr_beat < 2) else begin
          $display("write-back burst at %h is not a line-aligned two-beat burst", wr_addr);
          errors++;
        end
        wmem[wr_addr + 8 * wr_beat] = mem_w_data_o;
        wr_beat <= wr_beat + 1;
        if (wr_beat == 1) begin
          mem_b_valid_i <= 1'b1;
          bursts++;
        end
      end
      if (mem_b_valid_i && mem_b_ready_o) mem_b_valid_i <= 1'b0;
    end
  end

  // counts falling edges until the signal is high or the timeout hits
  task automatic wait_high(ref logic sig, input string what, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!sig && cycles < TIMEOUT);
    if (!sig) begin
      $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
      cycles = 0;
      run_ok = 1'b0;
    end
  endtask

  task automatic do_read(input addr_t a, input word_t exp, input bit hit);
    int n;
    @(posedge clk);
    cpu_ar_valid_i <= 1'b1;
    cpu_ar_addr_i  <= a;
    wait_high(cpu_ar_ready_o, "read address ready", n);
    @(posedge clk);
    cpu_ar_valid_i <= 1'b0;
    if (run_ok) wait_high(cpu_r_valid_o, "read data valid", n);
    if (run_ok && hit) begin
      assert (n == 1) else begin
        $display("MISMATCH at %0t: read hit took %0d cycles, expected 1", $time, n);
        errors++;
      end
    end
    if (run_ok) begin
      assert (cpu_r_data_o == exp) else begin
        $display("MISMATCH at %0t: read %h got %h expected %h", $time, a, cpu_r_data_o, exp);
        errors++;
      end
    end
  endtask

  task automatic do_write(input addr_t a, input word_t d, input strb_t s);
    int    n;
    addr_t wa;
    word_t w;
    wa = {a[31:3], 3'b000};
    w  = ref_word(wa);
    for (int b = 0; b < 8; b++) begin
      if (s[b]) w[b*8 +: 8] = d[b*8 +: 8];
    end
    ref_mem[wa] = w;
    @(posedge clk);
    cpu_aw_valid_i <= 1'b1;
    cpu_aw_addr_i  <= a;
    wait_high(cpu_aw_ready_o, "write address ready", n);
    @(posedge clk);
    cpu_aw_valid_i <= 1'b0;
    cpu_w_valid_i  <= 1'b1;
    cpu_w_data_i   <= d;
    cpu_w_strb_i   <= s;
    if (run_ok) wait_high(cpu_w_ready_o, "write data ready", n);
    @(posedge clk);
    cpu_w_valid_i <= 1'b0;
    if (run_ok) wait_high(cpu_b_valid_o, "write response valid", n);
  endtask

  task automatic note_test(input string name, input int errs_before);
    if (errors == errs_before && run_ok) begin
      passed++;
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: failed", name);
    end
  endtask

  initial begin
    int    idx, e0;
    rst = 1'b1;
    {cpu_ar_valid_i, cpu_r_ready_i, cpu_aw_valid_i, cpu_w_valid_i, cpu_b_ready_i} = '0;
    cpu_ar_addr_i = '0;
    cpu_aw_addr_i = '0;
    cpu_w_data_i  = '0;
    cpu_w_strb_i  = '0;
    {mem_ar_ready_i, mem_r_valid_i, mem_aw_ready_i, mem_w_ready_i, mem_b_valid_i} = '0;
    mem_r_data_i  = '0;
    {errors, passed, failed, bursts, rd_beat, wr_beat} = '0;
    run_ok = 1'b1;
    $readmemh("bench/dcache_golden.txt", golden);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    e0 = errors;
    @(negedge clk);
    assert (!(cpu_ar_ready_o | cpu_aw_ready_o | cpu_r_valid_o | cpu_w_ready_o | cpu_b_valid_o |
              mem_ar_valid_o | mem_aw_valid_o | mem_w_valid_o | mem_r_ready_o | mem_b_ready_o))
    else begin
      $display("valid or ready output high right after reset");
      errors++;
    end
    @(negedge clk);
    assert (cpu_ar_ready_o && cpu_aw_ready_o) else begin
      $display("address ready outputs did not rise in the first cycle after reset");
      errors++;
    end
    note_test("reset state", e0);
    @(posedge clk);
    cpu_r_ready_i <= 1'b1;
    cpu_b_ready_i <= 1'b1;
    idx = 0;
    while (run_ok && golden[idx*5] != 64'hf) begin
      e0 = errors;
      if (golden[idx*5] == 64'h1) begin
        do_write(golden[idx*5+1][31:0], golden[idx*5+2], golden[idx*5+3][7:0]);
      end else begin
        do_read(golden[idx*5+1][31:0], golden[idx*5+4], golden[idx*5] == 64'h2);
      end
      note_test($sformatf("test %0d op %0h addr %h", idx, golden[idx*5], golden[idx*5+1]), e0);
      idx++;
    end
    e0 = errors;
    assert (bursts > 0) else begin
      $display("no dirty line was written back to memory");
      errors++;
    end
    note_test("eviction bursts", e0);
    $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
    if (errors == 0 && run_ok) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* bench/dcache_golden.txt */
// op (0 read, 1 write, 2 read expecting hit timing, f end) address write_data strobe
// expected_read_data; reads ignore data and strobe, writes ignore the expected value
0 00001000 0000000000000000 00 00001000ffffefff
0 00002018 0000000000000000 00 00002018ffffdfe7
2 00001000 0000000000000000 00 00001000ffffefff
2 00001008 0000000000000000 00 00001008ffffeff7
2 00002018 0000000000000000 00 00002018ffffdfe7
1 00001000 1122334455667788 0f 0000000000000000
2 00001000 0000000000000000 00 0000100055667788
1 00002018 aabbccdd00000000 f0 0000000000000000
2 00002018 0000000000000000 00 aabbccddffffdfe7
1 00003020 0123456789abcdef ff 0000000000000000
2 00003020 0000000000000000 00 0123456789abcdef
2 00003028 0000000000000000 00 00003028ffffcfd7
1 00004030 1111111111111111 ff 0000000000000000
1 00005030 2222222222222222 ff 0000000000000000
1 00006030 3333333333333333 ff 0000000000000000
1 00004038 4444444444444444 ff 0000000000000000
0 00004030 0000000000000000 00 1111111111111111
0 00005030 0000000000000000 00 2222222222222222
0 00006030 0000000000000000 00 3333333333333333
0 00004038 0000000000000000 00 4444444444444444
0 00005038 0000000000000000 00 00005038ffffafc7
0 00001008 0000000000000000 00 00001008ffffeff7
f 00000000 0000000000000000 00 0000000000000000

/* verilog.f */
verilog/dcache_pkg.sv
verilog/tag_if.sv
verilog/line_if.sv
verilog/dcache_tag_store.sv
verilog/dcache_line_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
bench/dcache_assert.sv
bench/tb_dcache.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
  -f verilog.f -o sim_dcache \
  && ./obj_dir/sim_dcache > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Assertion failed" sim.log && { echo "assertion FAILED"; exit 1; }
echo "simulation passed"
exit 0
